/* execute_stage.f */
source/exec_pkg.sv
source/exec_alu.sv
source/exec_multiply.sv
source/exec_divide.sv
source/exec_core.sv
source/execute_stage.sv
testbench/execute_stage_tb.sv

/* Makefile */
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP ?= execute_stage_tb
FILE_LIST ?= execute_stage.f
BUILD_DIR ?= build
LOG ?= $(BUILD_DIR)/sim.log
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= All tests passed!

SOURCES := $(wildcard source/*.sv testbench/*.sv)
BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BINARY) > $(LOG) 2>&1; cat $(LOG)
	@grep -q '$(PASS_TEXT)' $(LOG)

clean:
	rm -rf $(BUILD_DIR)

/* testbench/execute_stage_tb.sv */
// ============================================================
// Execute stage testbench
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module execute_stage_tb;

	localparam int W = exec_pkg::XLEN;
	localparam int WAIT_LIMIT = 200;

	logic i_clock;
	logic i_reset;
	logic i_memory_busy;
	exec_pkg::decode_data_t i_data;
	logic [W-1:0] i_rs1;
	logic [W-1:0] i_rs2;
	exec_pkg::execute_data_t o_data;
	logic o_busy;
	logic o_jump;
	logic [W-1:0] o_jump_pc;
	logic o_fault;

	int error_count;
	int check_count;

	execute_stage i_dut (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_memory_busy(i_memory_busy),
		.i_data(i_data),
		.i_rs1(i_rs1),
		.i_rs2(i_rs2),
		.o_data(o_data),
		.o_busy(o_busy),
		.o_jump(o_jump),
		.o_jump_pc(o_jump_pc),
		.o_fault(o_fault)
	);

	initial i_clock = 1'b0;
	always #5 i_clock = ~i_clock;

	// ============================================================
	// Reference model
	function automatic logic [W-1:0] pick_operand(input exec_pkg::operand_sel_e sel,
		input exec_pkg::decode_data_t instr, input logic [W-1:0] rs1,
		input logic [W-1:0] rs2);
		case (sel)
			exec_pkg::SEL_RS1: return rs1;
			exec_pkg::SEL_RS2: return rs2;
			exec_pkg::SEL_PC:  return instr.pc;
			exec_pkg::SEL_IMM: return instr.imm;
			default:           return '0;
		endcase
	endfunction

	function automatic logic [W-1:0] alu_model(input exec_pkg::alu_op_e op,
		input logic [W-1:0] a, input logic [W-1:0] b);
		case (op)
			exec_pkg::ALU_ADD:  return a + b;
			exec_pkg::ALU_SUB:  return a - b;
			exec_pkg::ALU_AND:  return a & b;
			exec_pkg::ALU_OR:   return a | b;
			exec_pkg::ALU_XOR:  return a ^ b;
			exec_pkg::ALU_SLL:  return a << b[4:0];
			exec_pkg::ALU_SRL:  return a >> b[4:0];
			exec_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
			exec_pkg::ALU_SLT, exec_pkg::ALU_BLT: return {31'b0, $signed(a) < $signed(b)};
			exec_pkg::ALU_SLTU, exec_pkg::ALU_BLTU: return {31'b0, a < b};
			exec_pkg::ALU_BEQ:  return {31'b0, a == b};
			exec_pkg::ALU_BNE:  return {31'b0, a != b};
			exec_pkg::ALU_BGE:  return {31'b0, $signed(a) >= $signed(b)};
			default:            return {31'b0, a >= b};
		endcase
	endfunction

	function automatic logic [W-1:0] mdu_model(input exec_pkg::mdu_op_e op,
		input logic [W-1:0] a, input logic [W-1:0] b);
		longint sa;
		longint sb;
		logic [63:0] signed_product;
		logic [63:0] unsigned_product;
		longint quotient;
		longint remainder;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		signed_product = sa * sb;
		unsigned_product = {32'b0, a} * {32'b0, b};
		case (op)
			exec_pkg::MDU_MUL:   return unsigned_product[31:0];
			exec_pkg::MDU_MULH:  return signed_product[63:32];
			exec_pkg::MDU_MULHU: return unsigned_product[63:32];
			exec_pkg::MDU_DIVU:  return (b == 0) ? '1 : a / b;
			exec_pkg::MDU_REMU:  return (b == 0) ? a : a % b;
			default: ;
		endcase
		// Signed divide, zero divisor and overflow first
		if (b == 0)
			return (op == exec_pkg::MDU_DIV) ? '1 : a;
		if (a == 32'h8000_0000 && b == 32'hffff_ffff)
			return (op == exec_pkg::MDU_DIV) ? a : '0;
		quotient = sa / sb;
		remainder = sa % sb;
		return (op == exec_pkg::MDU_DIV) ? quotient[31:0] : remainder[31:0];
	endfunction

	// ============================================================
	// Drive and check helpers
	function automatic exec_pkg::decode_data_t make_instr(input exec_pkg::op_class_e op_class,
		input exec_pkg::alu_op_e alu_op, input exec_pkg::operand_sel_e sel1,
		input exec_pkg::operand_sel_e sel2);
		exec_pkg::decode_data_t instr;
		instr = '0;
		instr.op_class = op_class;
		instr.alu_op = alu_op;
		instr.operand1_sel = sel1;
		instr.operand2_sel = sel2;
		instr.pc = $urandom() & 32'hffff_fffc;
		instr.imm = $urandom();
		instr.rd = 5'($urandom_range(31, 1));
		instr.mem_width = 2'd2;
		return instr;
	endfunction

	task automatic check_word(input string name, input logic [W-1:0] expected,
		input logic [W-1:0] actual);
		check_count++;
		assert (actual === expected) else begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic apply_reset();
		@(negedge i_clock);
		i_reset = 1'b1;
		i_memory_busy = 1'b0;
		i_data = '0;
		i_rs1 = '0;
		i_rs2 = '0;
		repeat (5) @(negedge i_clock);
		i_reset = 1'b0;
	endtask

	// New instruction marked by a toggled strobe
	task automatic issue(input exec_pkg::decode_data_t instr, input logic [W-1:0] rs1,
		input logic [W-1:0] rs2);
		@(negedge i_clock);
		instr.strobe = ~i_data.strobe;
		i_data = instr;
		i_rs1 = rs1;
		i_rs2 = rs2;
	endtask

	task automatic wait_result(input string name, input logic expect_busy, output int edges);
		int cycles;
		logic done;
		cycles = 0;
		done = 1'b0;
		while (!done && cycles < WAIT_LIMIT) begin
			@(negedge i_clock);
			cycles++;
			if (o_data.strobe == i_data.strobe)
				done = 1'b1;
			else if (expect_busy)
				check_word({name, " busy"}, 32'd1, 32'(o_busy));
		end
		assert (done) else begin
			$display("Timeout in %s: the output strobe never toggled", name);
			error_count++;
		end
		check_word({name, " busy after"}, 32'd0, 32'(o_busy));
		edges = cycles - 1;
	endtask

	task automatic check_jump_pulse(input string name, input logic [W-1:0] target);
		check_word({name, " jump"}, 32'd1, 32'(o_jump));
		check_word({name, " jump_pc"}, target, o_jump_pc);
		@(negedge i_clock);
		check_word({name, " jump length"}, 32'd0, 32'(o_jump));
	endtask

	// ============================================================
	// Directed tests
	task automatic test_alu();
		exec_pkg::decode_data_t instr;
		exec_pkg::alu_op_e op;
		exec_pkg::op_class_e op_class;
		logic [W-1:0] rs1;
		logic [W-1:0] rs2;
		logic [W-1:0] operand1;
		logic [W-1:0] operand2;
		int edges;
		for (int k = 0; k < 10; k++) begin
			op = exec_pkg::alu_op_e'(k);
			if (k < 5)
				op_class = exec_pkg::CLASS_ARITHMETIC;
			else if (k < 8)
				op_class = exec_pkg::CLASS_SHIFT;
			else
				op_class = exec_pkg::CLASS_COMPARE;
			// Every source shows up on both operand sides
			for (int s = 0; s < 5; s++) begin
				instr = make_instr(op_class, op, exec_pkg::operand_sel_e'(s),
					exec_pkg::operand_sel_e'(4 - s));
				rs1 = $urandom();
				rs2 = $urandom();
				operand1 = pick_operand(instr.operand1_sel, instr, rs1, rs2);
				operand2 = pick_operand(instr.operand2_sel, instr, rs1, rs2);
				issue(instr, rs1, rs2);
				wait_result("alu", 1'b0, edges);
				check_word("alu rd_value", alu_model(op, operand1, operand2), o_data.rd_value);
				check_word("alu rd", 32'(instr.rd), 32'(o_data.rd));
				check_word("alu pc", instr.pc, o_data.pc);
				check_word("alu mem_address", rs1 + instr.imm, o_data.mem_address);
				check_word("alu accept edge", 32'd0, edges);
			end
		end
	endtask

	task automatic test_jump_branch();
		exec_pkg::decode_data_t instr;
		exec_pkg::alu_op_e op;
		logic [W-1:0] rs1;
		logic [W-1:0] rs2;
		logic [W-1:0] low;
		logic [W-1:0] high;
		logic [W-1:0] target;
		int edges;
		instr = make_instr(exec_pkg::CLASS_JUMP, exec_pkg::ALU_ADD, exec_pkg::SEL_RS1,
			exec_pkg::SEL_IMM);
		rs1 = $urandom();
		issue(instr, rs1, $urandom());
		wait_result("jump", 1'b0, edges);
		check_word("jump rd_value", instr.pc + 32'd4, o_data.rd_value);
		check_jump_pulse("jump", rs1 + instr.imm);
		for (int k = 10; k < 16; k++) begin
			op = exec_pkg::alu_op_e'(k);
			// Pair order flips between signed and unsigned conditions
			if (op == exec_pkg::ALU_BLTU || op == exec_pkg::ALU_BGEU) begin
				low = 32'h0000_0010;
				high = 32'hffff_fff0;
			end else begin
				low = 32'hffff_fff0;
				high = 32'h0000_0010;
			end
			for (int p = 0; p < 3; p++) begin
				instr = make_instr(exec_pkg::CLASS_BRANCH, op, exec_pkg::SEL_RS1,
					exec_pkg::SEL_RS2);
				if (p == 0) begin
					rs1 = $urandom();
					rs2 = rs1;
				end else if (p == 1) begin
					rs1 = low;
					rs2 = high;
				end else begin
					rs1 = high;
					rs2 = low;
				end
				if (alu_model(op, rs1, rs2) != '0)
					target = instr.pc + instr.imm;
				else
					target = instr.pc + 32'd4;
				issue(instr, rs1, rs2);
				wait_result("branch", 1'b0, edges);
				check_jump_pulse("branch", target);
			end
		end
	endtask

	task automatic test_load_store();
		exec_pkg::decode_data_t instr;
		logic [W-1:0] rs1;
		logic [W-1:0] rs2;
		int edges;
		instr = make_instr(exec_pkg::CLASS_LOAD, exec_pkg::ALU_ADD, exec_pkg::SEL_RS1,
			exec_pkg::SEL_IMM);
		instr.mem_width = 2'd0;
		instr.mem_signed = 1'b1;
		rs1 = $urandom();
		issue(instr, rs1, $urandom());
		wait_result("load", 1'b0, edges);
		check_word("load rd", 32'd0, 32'(o_data.rd));
		check_word("load mem_read", 32'd1, 32'(o_data.mem_read));
		check_word("load mem_write", 32'd0, 32'(o_data.mem_write));
		check_word("load mem_width", 32'd0, 32'(o_data.mem_width));
		check_word("load mem_signed", 32'd1, 32'(o_data.mem_signed));
		check_word("load mem_rd", 32'(instr.rd), 32'(o_data.mem_rd));
		check_word("load mem_address", rs1 + instr.imm, o_data.mem_address);

		instr = make_instr(exec_pkg::CLASS_STORE, exec_pkg::ALU_ADD, exec_pkg::SEL_RS1,
			exec_pkg::SEL_IMM);
		instr.mem_width = 2'd1;
		rs1 = $urandom();
		rs2 = $urandom();
		issue(instr, rs1, rs2);
		wait_result("store", 1'b0, edges);
		check_word("store rd_value", rs2, o_data.rd_value);
		check_word("store mem_write", 32'd1, 32'(o_data.mem_write));
		check_word("store mem_read", 32'd0, 32'(o_data.mem_read));
		check_word("store mem_width", 32'd1, 32'(o_data.mem_width));
		check_word("store mem_address", rs1 + instr.imm, o_data.mem_address);
	endtask

	task automatic test_multiply_divide();
		logic [W-1:0] corner_a [8] = '{32'h0, 32'h7, 32'h8000_0000, 32'hffff_ffff,
			32'h8000_0000, 32'hffff_fff9, 32'h7, 32'h0001_e240};
		logic [W-1:0] corner_b [8] = '{32'h0, 32'h0, 32'hffff_ffff, 32'hffff_ffff,
			32'h8000_0000, 32'h2, 32'hffff_fffe, 32'd100};
		exec_pkg::decode_data_t instr;
		exec_pkg::mdu_op_e variant;
		exec_pkg::op_class_e op_class;
		logic [W-1:0] a;
		logic [W-1:0] b;
		int edges;
		for (int n = 0; n < 12; n++) begin
			a = (n < 8) ? corner_a[n] : $urandom();
			b = (n < 8) ? corner_b[n] : $urandom();
			for (int v = 0; v < 7; v++) begin
				variant = exec_pkg::mdu_op_e'(v);
				if (v < 3)
					op_class = exec_pkg::CLASS_MULTIPLY;
				else
					op_class = exec_pkg::CLASS_DIVIDE;
				instr = make_instr(op_class, exec_pkg::ALU_ADD, exec_pkg::SEL_RS1,
					exec_pkg::SEL_RS2);
				instr.mdu_op = variant;
				issue(instr, a, b);
				wait_result("mdu", 1'b1, edges);
				check_word("mdu rd_value", mdu_model(variant, a, b), o_data.rd_value);
				if (v < 3)
					check_word("multiply latency", exec_pkg::MUL_LATENCY + 1, edges);
			end
		end
	endtask

	task automatic test_back_pressure();
		exec_pkg::decode_data_t instr;
		exec_pkg::execute_data_t snapshot;
		logic [W-1:0] rs1;
		logic [W-1:0] rs2;
		int edges;
		// Single-cycle add held off by the memory stage
		instr = make_instr(exec_pkg::CLASS_ARITHMETIC, exec_pkg::ALU_ADD, exec_pkg::SEL_RS1,
			exec_pkg::SEL_RS2);
		rs1 = $urandom();
		rs2 = $urandom();
		snapshot = o_data;
		@(negedge i_clock);
		i_memory_busy = 1'b1;
		issue(instr, rs1, rs2);
		repeat (6) begin
			@(negedge i_clock);
			check_word("stall add strobe", 32'(snapshot.strobe), 32'(o_data.strobe));
			check_word("stall add hold", snapshot.rd_value, o_data.rd_value);
		end
		i_memory_busy = 1'b0;
		wait_result("stall add", 1'b0, edges);
		check_word("stall add rd_value", rs1 + rs2, o_data.rd_value);

		// Multiply finishes inside the stall and completes after release
		instr = make_instr(exec_pkg::CLASS_MULTIPLY, exec_pkg::ALU_ADD, exec_pkg::SEL_RS1,
			exec_pkg::SEL_RS2);
		instr.mdu_op = exec_pkg::MDU_MULHU;
		rs1 = $urandom();
		rs2 = $urandom();
		snapshot = o_data;
		issue(instr, rs1, rs2);
		@(negedge i_clock);
		i_memory_busy = 1'b1;
		repeat (10) begin
			@(negedge i_clock);
			check_word("stall multiply strobe", 32'(snapshot.strobe), 32'(o_data.strobe));
			check_word("stall multiply busy", 32'd1, 32'(o_busy));
		end
		i_memory_busy = 1'b0;
		wait_result("stall multiply", 1'b1, edges);
		check_word("stall multiply rd_value", mdu_model(exec_pkg::MDU_MULHU, rs1, rs2),
			o_data.rd_value);

		// Same strobe with new operands runs nothing
		instr = make_instr(exec_pkg::CLASS_JUMP, exec_pkg::ALU_ADD, exec_pkg::SEL_RS1,
			exec_pkg::SEL_IMM);
		rs1 = $urandom();
		issue(instr, rs1, rs2);
		wait_result("repeat jump", 1'b0, edges);
		check_jump_pulse("repeat jump", rs1 + instr.imm);
		snapshot = o_data;
		i_rs1 = ~rs1;
		repeat (5) begin
			@(negedge i_clock);
			check_word("repeat strobe", 32'(snapshot.strobe), 32'(o_data.strobe));
			check_word("repeat mem_address", snapshot.mem_address, o_data.mem_address);
			check_word("repeat jump", 32'd0, 32'(o_jump));
		end
	endtask

	task automatic test_fault();
		exec_pkg::decode_data_t instr;
		exec_pkg::execute_data_t snapshot;
		snapshot = o_data;
		instr = make_instr(exec_pkg::CLASS_INVALID, exec_pkg::ALU_ADD, exec_pkg::SEL_RS1,
			exec_pkg::SEL_RS2);
		issue(instr, $urandom(), $urandom());
		repeat (5) begin
			@(negedge i_clock);
			check_word("fault strobe", 32'(snapshot.strobe), 32'(o_data.strobe));
		end
		check_word("fault flag", 32'd1, 32'(o_fault));
		apply_reset();
		check_word("reset fault", 32'd0, 32'(o_fault));
		check_word("reset strobe", 32'd0, 32'(o_data.strobe));
		check_word("reset rd_value", 32'd0, o_data.rd_value);
		check_word("reset jump", 32'd0, 32'(o_jump));
		check_word("reset busy", 32'd0, 32'(o_busy));
	endtask

	// ============================================================
	// Main sequence
	initial begin
		error_count = 0;
		check_count = 0;
		void'($urandom(32'h7ac4));
		i_reset = 1'b1;
		i_memory_busy = 1'b0;
		i_data = '0;
		i_rs1 = '0;
		i_rs2 = '0;
		apply_reset();

		test_alu();
		test_jump_branch();
		test_load_store();
		test_multiply_divide();
		test_back_pressure();
		test_fault();

		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

/* source/execute_stage.sv */
// ============================================================
// Execute stage top level
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input wire i_clock,
	input wire i_reset,
	input wire i_memory_busy,
	input wire exec_pkg::decode_data_t i_data,
	input wire [exec_pkg::XLEN-1:0] i_rs1,
	input wire [exec_pkg::XLEN-1:0] i_rs2,
	output exec_pkg::execute_data_t o_data,
	output logic o_busy,
	output logic o_jump,
	output logic [exec_pkg::XLEN-1:0] o_jump_pc,
	output logic o_fault
);

	exec_pkg::alu_op_e alu_op;
	logic [exec_pkg::XLEN-1:0] alu_operand1;
	logic [exec_pkg::XLEN-1:0] alu_operand2;
	logic [exec_pkg::XLEN-1:0] alu_result;
	logic [exec_pkg::XLEN-1:0] alu_shift_result;
	logic [exec_pkg::XLEN-1:0] alu_signed_sum_result;
	logic alu_compare_result;

	logic mul_latch;
	logic mul_signed;
	logic mul_ready;
	logic [2*exec_pkg::XLEN-1:0] mul_product;

	logic div_latch;
	logic div_signed;
	logic div_ready;
	logic [exec_pkg::XLEN-1:0] div_quotient;
	logic [exec_pkg::XLEN-1:0] div_remainder;

	exec_core i_core (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_memory_busy(i_memory_busy),
		.i_data(i_data),
		.i_rs1(i_rs1),
		.i_rs2(i_rs2),
		.o_data(o_data),
		.o_busy(o_busy),
		.o_jump(o_jump),
		.o_jump_pc(o_jump_pc),
		.o_fault(o_fault),
		.o_alu_op(alu_op),
		.o_alu_operand1(alu_operand1),
		.o_alu_operand2(alu_operand2),
		.i_alu_result(alu_result),
		.i_alu_shift_result(alu_shift_result),
		.i_alu_signed_sum_result(alu_signed_sum_result),
		.i_alu_compare_result(alu_compare_result),
		.o_mul_latch(mul_latch),
		.o_mul_signed(mul_signed),
		.i_mul_ready(mul_ready),
		.i_mul_product(mul_product),
		.o_div_latch(div_latch),
		.o_div_signed(div_signed),
		.i_div_ready(div_ready),
		.i_div_quotient(div_quotient),
		.i_div_remainder(div_remainder)
	);

	exec_alu i_alu (
		.i_op(alu_op),
		.i_operand1(alu_operand1),
		.i_operand2(alu_operand2),
		.o_result(alu_result),
		.o_shift_result(alu_shift_result),
		.o_signed_sum_result(alu_signed_sum_result),
		.o_compare_result(alu_compare_result)
	);

	// Units take the register operands in the latch cycle only
	exec_multiply i_multiply (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_latch(mul_latch),
		.i_signed(mul_signed),
		.i_operand1(i_rs1),
		.i_operand2(i_rs2),
		.o_ready(mul_ready),
		.o_product(mul_product)
	);

	exec_divide i_divide (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_latch(div_latch),
		.i_signed(div_signed),
		.i_numerator(i_rs1),
		.i_denominator(i_rs2),
		.o_ready(div_ready),
		.o_quotient(div_quotient),
		.o_remainder(div_remainder)
	);

endmodule

`default_nettype wire

/* source/exec_core.sv */
// ============================================================
// Execute stage control and dispatch
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module exec_core (
	input wire i_clock,
	input wire i_reset,
	input wire i_memory_busy,
	input wire exec_pkg::decode_data_t i_data,
	input wire [exec_pkg::XLEN-1:0] i_rs1,
	input wire [exec_pkg::XLEN-1:0] i_rs2,
	output exec_pkg::execute_data_t o_data,
	output logic o_busy,
	output logic o_jump,
	output logic [exec_pkg::XLEN-1:0] o_jump_pc,
	output logic o_fault,

	// ALU
	output exec_pkg::alu_op_e o_alu_op,
	output logic [exec_pkg::XLEN-1:0] o_alu_operand1,
	output logic [exec_pkg::XLEN-1:0] o_alu_operand2,
	input wire [exec_pkg::XLEN-1:0] i_alu_result,
	input wire [exec_pkg::XLEN-1:0] i_alu_shift_result,
	input wire [exec_pkg::XLEN-1:0] i_alu_signed_sum_result,
	input wire i_alu_compare_result,

	// Multiplier and divider
	output logic o_mul_latch,
	output logic o_mul_signed,
	input wire i_mul_ready,
	input wire [2*exec_pkg::XLEN-1:0] i_mul_product,
	output logic o_div_latch,
	output logic o_div_signed,
	input wire i_div_ready,
	input wire [exec_pkg::XLEN-1:0] i_div_quotient,
	input wire [exec_pkg::XLEN-1:0] i_div_remainder
);

	localparam int W = exec_pkg::XLEN;

	logic last_strobe;
	logic pending;
	logic held_valid;
	logic [W-1:0] held_value;
	logic new_strobe;
	logic accept;
	logic is_single;
	logic is_mdu;
	logic is_flow;
	logic mdu_ready;
	logic finish_mdu;
	logic [W-1:0] mdu_value;
	logic [W-1:0] single_value;
	logic [W-1:0] jump_target;
	exec_pkg::execute_data_t result_data;

	function automatic logic [W-1:0] select_operand(
		input exec_pkg::operand_sel_e sel,
		input logic [W-1:0] pc,
		input logic [W-1:0] imm,
		input logic [W-1:0] rs1,
		input logic [W-1:0] rs2
	);
		case (sel)
			exec_pkg::SEL_RS1: return rs1;
			exec_pkg::SEL_RS2: return rs2;
			exec_pkg::SEL_PC:  return pc;
			exec_pkg::SEL_IMM: return imm;
			default:           return '0;
		endcase
	endfunction

	assign o_alu_op = i_data.alu_op;
	assign o_alu_operand1 = select_operand(i_data.operand1_sel, i_data.pc, i_data.imm,
		i_rs1, i_rs2);
	assign o_alu_operand2 = select_operand(i_data.operand2_sel, i_data.pc, i_data.imm,
		i_rs1, i_rs2);

	// ============================================================
	// Dispatch decisions
	assign new_strobe = (i_data.strobe != last_strobe);
	assign accept = !i_memory_busy && new_strobe && !pending;
	assign is_mdu = (i_data.op_class == exec_pkg::CLASS_MULTIPLY)
		|| (i_data.op_class == exec_pkg::CLASS_DIVIDE);
	assign is_flow = (i_data.op_class == exec_pkg::CLASS_JUMP)
		|| (i_data.op_class == exec_pkg::CLASS_BRANCH);
	assign o_busy = new_strobe && is_mdu;

	assign o_mul_latch = accept && (i_data.op_class == exec_pkg::CLASS_MULTIPLY);
	assign o_mul_signed = (i_data.mdu_op != exec_pkg::MDU_MULHU);
	assign o_div_latch = accept && (i_data.op_class == exec_pkg::CLASS_DIVIDE);
	assign o_div_signed = (i_data.mdu_op == exec_pkg::MDU_DIV)
		|| (i_data.mdu_op == exec_pkg::MDU_REM);

	assign mdu_ready = (i_data.op_class == exec_pkg::CLASS_MULTIPLY) ? i_mul_ready : i_div_ready;
	// Result kept in held_value if it arrived during memory back-pressure
	assign finish_mdu = pending && !i_memory_busy && (mdu_ready || held_valid);

	always_comb begin
		case (i_data.mdu_op)
			exec_pkg::MDU_MUL: mdu_value = i_mul_product[W-1:0];
			exec_pkg::MDU_MULH, exec_pkg::MDU_MULHU: mdu_value = i_mul_product[2*W-1:W];
			exec_pkg::MDU_DIV, exec_pkg::MDU_DIVU: mdu_value = i_div_quotient;
			default: mdu_value = i_div_remainder;
		endcase
	end

	always_comb begin
		is_single = 1'b1;
		single_value = '0;
		case (i_data.op_class)
			exec_pkg::CLASS_ARITHMETIC: single_value = i_alu_result;
			exec_pkg::CLASS_SHIFT: single_value = i_alu_shift_result;
			exec_pkg::CLASS_COMPARE: single_value = {{(W-1){1'b0}}, i_alu_compare_result};
			exec_pkg::CLASS_JUMP: single_value = i_data.pc + 'd4;
			exec_pkg::CLASS_STORE: single_value = i_rs2;
			exec_pkg::CLASS_BRANCH, exec_pkg::CLASS_LOAD: ;
			default: is_single = 1'b0;
		endcase
	end

	always_comb begin
		if (i_data.op_class == exec_pkg::CLASS_JUMP)
			jump_target = i_alu_signed_sum_result;
		else if (i_alu_compare_result)
			jump_target = i_data.pc + i_data.imm;
		else
			jump_target = i_data.pc + 'd4;
	end

	always_comb begin
		result_data.strobe = ~o_data.strobe;
		result_data.pc = i_data.pc;
		result_data.rd_value = pending ? (held_valid ? held_value : mdu_value) : single_value;
		// Loads write rd later in the memory stage
		result_data.rd = (i_data.op_class == exec_pkg::CLASS_LOAD) ? '0 : i_data.rd;
		result_data.mem_read = (i_data.op_class == exec_pkg::CLASS_LOAD);
		result_data.mem_write = (i_data.op_class == exec_pkg::CLASS_STORE);
		result_data.mem_width = i_data.mem_width;
		result_data.mem_signed = i_data.mem_signed;
		result_data.mem_address = i_rs1 + i_data.imm;
		result_data.mem_rd = i_data.rd;
	end

	// ============================================================
	// State update
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_data <= '0;
			o_jump <= 1'b0;
			o_jump_pc <= '0;
			o_fault <= 1'b0;
			last_strobe <= 1'b0;
			pending <= 1'b0;
			held_valid <= 1'b0;
		end else begin
			o_jump <= 1'b0;
			if (finish_mdu) begin
				o_data <= result_data;
				last_strobe <= i_data.strobe;
				pending <= 1'b0;
				held_valid <= 1'b0;
			end else if (pending && mdu_ready) begin
				held_valid <= 1'b1;
			end else if (accept) begin
				if (is_single) begin
					o_data <= result_data;
					last_strobe <= i_data.strobe;
					if (is_flow) begin
						o_jump <= 1'b1;
						o_jump_pc <= jump_target;
					end
				end else if (is_mdu) begin
					pending <= 1'b1;
				end else begin
					// Unknown class, most likely a decode bug
					o_fault <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (pending && mdu_ready)
			held_value <= mdu_value;
	end

endmodule

`default_nettype wire

/* source/exec_divide.sv */
// ============================================================
// Restoring divider
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module exec_divide (
	input wire i_clock,
	input wire i_reset,
	input wire i_latch,
	input wire i_signed,
	input wire [exec_pkg::XLEN-1:0] i_numerator,
	input wire [exec_pkg::XLEN-1:0] i_denominator,
	output logic o_ready,
	output logic [exec_pkg::XLEN-1:0] o_quotient,
	output logic [exec_pkg::XLEN-1:0] o_remainder
);

	localparam int W = exec_pkg::XLEN;

	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_RUN,
		DIV_FIXUP
	} div_state_e;

	div_state_e state;
	logic [$clog2(W)-1:0] count;
	// Dividend shifts out on top while quotient bits shift in below
	logic [W-1:0] dividend;
	logic [W-1:0] divisor;
	logic [W:0] partial;
	logic [W:0] shifted;
	logic [W:0] trial;
	logic negate_quotient;
	logic negate_remainder;

	assign shifted = {partial[W-1:0], dividend[W-1]};
	assign trial = shifted - {1'b0, divisor};

	// ============================================================
	// Control
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= DIV_IDLE;
			count <= '0;
			o_ready <= 1'b0;
		end else begin
			o_ready <= 1'b0;
			case (state)
				DIV_IDLE: begin
					count <= '0;
					if (i_latch)
						state <= DIV_RUN;
				end
				DIV_RUN: begin
					count <= count + 1'b1;
					if (count == W - 1)
						state <= DIV_FIXUP;
				end
				DIV_FIXUP: begin
					o_ready <= 1'b1;
					state <= DIV_IDLE;
				end
				default: state <= DIV_IDLE;
			endcase
		end
	end

	// ============================================================
	// Datapath
	always_ff @(posedge i_clock) begin
		case (state)
			DIV_IDLE: begin
				dividend <= (i_signed && i_numerator[W-1]) ? -i_numerator : i_numerator;
				divisor <= (i_signed && i_denominator[W-1]) ? -i_denominator : i_denominator;
				partial <= '0;
				// Zero divisor keeps the all-ones quotient unsigned
				negate_quotient <= i_signed && (i_numerator[W-1] ^ i_denominator[W-1])
					&& (i_denominator != '0);
				negate_remainder <= i_signed && i_numerator[W-1];
			end
			DIV_RUN: begin
				if (trial[W]) begin
					partial <= shifted;
					dividend <= {dividend[W-2:0], 1'b0};
				end else begin
					partial <= trial;
					dividend <= {dividend[W-2:0], 1'b1};
				end
			end
			DIV_FIXUP: begin
				// Divide by zero and overflow fall out of the plain algorithm
				o_quotient <= negate_quotient ? -dividend : dividend;
				o_remainder <= negate_remainder ? -partial[W-1:0] : partial[W-1:0];
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* source/exec_multiply.sv */
// ============================================================
// Pipelined multiplier
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module exec_multiply (
	input wire i_clock,
	input wire i_reset,
	input wire i_latch,
	input wire i_signed,
	input wire [exec_pkg::XLEN-1:0] i_operand1,
	input wire [exec_pkg::XLEN-1:0] i_operand2,
	output logic o_ready,
	output logic [2*exec_pkg::XLEN-1:0] o_product
);

	localparam int LAT = exec_pkg::MUL_LATENCY;

	// One extra bit so that MULHU and MULH share the signed multiply
	logic signed [exec_pkg::XLEN:0] operand1_q;
	logic signed [exec_pkg::XLEN:0] operand2_q;
	logic signed [2*exec_pkg::XLEN+1:0] full_product;
	logic operands_valid;
	logic [LAT-1:0] valid_pipe;
	logic [2*exec_pkg::XLEN-1:0] product_pipe [LAT];

	assign full_product = operand1_q * operand2_q;
	assign o_ready = valid_pipe[LAT-1];
	assign o_product = product_pipe[LAT-1];

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			operands_valid <= 1'b0;
			valid_pipe <= '0;
		end else begin
			operands_valid <= i_latch;
			valid_pipe <= {valid_pipe[LAT-2:0], operands_valid};
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_latch) begin
			operand1_q <= {i_signed & i_operand1[exec_pkg::XLEN-1], i_operand1};
			operand2_q <= {i_signed & i_operand2[exec_pkg::XLEN-1], i_operand2};
		end
		product_pipe[0] <= full_product[2*exec_pkg::XLEN-1:0];
		for (int i = 1; i < LAT; i++) begin
			product_pipe[i] <= product_pipe[i-1];
		end
	end

endmodule

`default_nettype wire

/* source/exec_alu.sv */
// ============================================================
// Integer ALU
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
	input wire exec_pkg::alu_op_e i_op,
	input wire [exec_pkg::XLEN-1:0] i_operand1,
	input wire [exec_pkg::XLEN-1:0] i_operand2,
	output logic [exec_pkg::XLEN-1:0] o_result,
	output logic [exec_pkg::XLEN-1:0] o_shift_result,
	output logic [exec_pkg::XLEN-1:0] o_signed_sum_result,
	output logic o_compare_result
);

	logic [$clog2(exec_pkg::XLEN)-1:0] shamt;
	logic equal;
	logic less_signed;
	logic less_unsigned;

	assign shamt = i_operand2[$clog2(exec_pkg::XLEN)-1:0];
	assign equal = (i_operand1 == i_operand2);
	assign less_signed = ($signed(i_operand1) < $signed(i_operand2));
	assign less_unsigned = (i_operand1 < i_operand2);

	// Used for jump targets
	assign o_signed_sum_result = $signed(i_operand1) + $signed(i_operand2);

	always_comb begin
		case (i_op)
			exec_pkg::ALU_SUB: o_result = i_operand1 - i_operand2;
			exec_pkg::ALU_AND: o_result = i_operand1 & i_operand2;
			exec_pkg::ALU_OR:  o_result = i_operand1 | i_operand2;
			exec_pkg::ALU_XOR: o_result = i_operand1 ^ i_operand2;
			default:           o_result = i_operand1 + i_operand2;
		endcase
	end

	always_comb begin
		case (i_op)
			exec_pkg::ALU_SLL: o_shift_result = i_operand1 << shamt;
			exec_pkg::ALU_SRA: o_shift_result = $signed(i_operand1) >>> shamt;
			default:           o_shift_result = i_operand1 >> shamt;
		endcase
	end

	// Set-less-than and all branch conditions
	always_comb begin
		case (i_op)
			exec_pkg::ALU_SLT, exec_pkg::ALU_BLT:   o_compare_result = less_signed;
			exec_pkg::ALU_SLTU, exec_pkg::ALU_BLTU: o_compare_result = less_unsigned;
			exec_pkg::ALU_BEQ:  o_compare_result = equal;
			exec_pkg::ALU_BNE:  o_compare_result = !equal;
			exec_pkg::ALU_BGE:  o_compare_result = !less_signed;
			exec_pkg::ALU_BGEU: o_compare_result = !less_unsigned;
			default:            o_compare_result = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* source/exec_pkg.sv */
// ============================================================
// Execute stage shared types
// ============================================================
`default_nettype none

package exec_pkg;

	localparam int XLEN = 32;
	localparam int REG_BITS = 5;
	// Cycles from multiplier latch to ready
	localparam int MUL_LATENCY = 3;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
		ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_SLT, ALU_SLTU, ALU_BEQ, ALU_BNE,
		ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
	} alu_op_e;

	typedef enum logic [3:0] {
		CLASS_ARITHMETIC, CLASS_SHIFT, CLASS_COMPARE, CLASS_JUMP, CLASS_BRANCH,
		CLASS_LOAD, CLASS_STORE, CLASS_MULTIPLY, CLASS_DIVIDE, CLASS_INVALID
	} op_class_e;

	typedef enum logic [2:0] {
		MDU_MUL, MDU_MULH, MDU_MULHU, MDU_DIV, MDU_DIVU, MDU_REM, MDU_REMU
	} mdu_op_e;

	typedef enum logic [2:0] {
		SEL_ZERO, SEL_RS1, SEL_RS2, SEL_PC, SEL_IMM
	} operand_sel_e;

	// Decoded instruction into the stage, strobe toggles per instruction
	typedef struct packed {
		logic strobe;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] imm;
		op_class_e op_class;
		alu_op_e alu_op;
		mdu_op_e mdu_op;
		operand_sel_e operand1_sel;
		operand_sel_e operand2_sel;
		logic [REG_BITS-1:0] rd;
		// Byte, half or word
		logic [1:0] mem_width;
		logic mem_signed;
	} decode_data_t;

	typedef struct packed {
		logic strobe;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] rd_value;
		logic [REG_BITS-1:0] rd;
		logic mem_read;
		logic mem_write;
		logic [1:0] mem_width;
		logic mem_signed;
		logic [XLEN-1:0] mem_address;
		logic [REG_BITS-1:0] mem_rd;
	} execute_data_t;

endpackage

`default_nettype wire
